/* fp16_mul_config.svh */
`ifndef FP16_MUL_CONFIG_SVH
`define FP16_MUL_CONFIG_SVH

// Binary16 field widths
`define FP16_EXP_W 5
`define FP16_MAN_W 10

// Exponent bias of the format
`define FP16_BIAS 15

// Biased exponent with all bits set, reserved for infinity and NaN
`define FP16_EXP_MAX 31

// Canonical quiet NaN returned for every NaN result
`define FP16_QNAN 16'h7E00

`endif

/* fp16_mul_pkg.sv */
`include "fp16_mul_config.svh"

package fp16_mul_pkg;

    // Binary16 word split into its fields
    typedef struct packed {
        logic                   sign;
        logic [`FP16_EXP_W-1:0] exp;
        logic [`FP16_MAN_W-1:0] man;
    } fp16_fields_t;

    // Same operand word, seen as raw bits or as fields
    // Raw view serves the NaN payload and quiet bit tests
    typedef union packed {
        logic [`FP16_EXP_W+`FP16_MAN_W:0] raw;
        fp16_fields_t                     f;
    } fp16_word_u;

    // Operand class, also reused as the special outcome of a product
    // CLS_NORMAL in the outcome means the arithmetic path decides
    typedef enum logic [2:0] {
        CLS_ZERO,
        CLS_NORMAL,
        CLS_INF,
        CLS_QNAN,
        CLS_SNAN
    } fp_class_e;

    // Exception flags reported with each result
    typedef struct packed {
        logic nv;
        logic of;
        logic uf;
        logic nx;
    } fp_status_t;

endpackage

/* fp16_mul_ifs.sv */
`timescale 1ns/10ps
`include "fp16_mul_config.svh"

// Decode to execute stage link
// Level signals, qualified by valid, no handshake
interface fp16_dec_exe_if;
    logic                          valid;
    // Sign of the product
    logic                          sign;
    // Sum of both unbiased exponents
    logic signed [`FP16_EXP_W+1:0] exp_sum;
    // Significands with the hidden one
    logic [`FP16_MAN_W:0]          man_a;
    logic [`FP16_MAN_W:0]          man_b;
    // Special outcome resolved in decode
    fp16_mul_pkg::fp_class_e       special;
    logic                          nv;

    modport src (
        output valid,
        output sign,
        output exp_sum,
        output man_a,
        output man_b,
        output special,
        output nv
    );

    modport dst (
        input valid,
        input sign,
        input exp_sum,
        input man_a,
        input man_b,
        input special,
        input nv
    );
endinterface

// Execute to result stage link
interface fp16_exe_res_if;
    logic                          valid;
    logic                          sign;
    logic signed [`FP16_EXP_W+1:0] exp_sum;
    // Full significand product, two integer bits
    logic [2*`FP16_MAN_W+1:0]      product;
    fp16_mul_pkg::fp_class_e       special;
    logic                          nv;

    modport src (
        output valid,
        output sign,
        output exp_sum,
        output product,
        output special,
        output nv
    );

    modport dst (
        input valid,
        input sign,
        input exp_sum,
        input product,
        input special,
        input nv
    );
endinterface

/* fp16_decode.sv */
`timescale 1ns/10ps
`include "fp16_mul_config.svh"

module fp16_decode (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [15:0] op_a_i,
    input  logic [15:0] op_b_i,
    input  logic        valid_i,
    fp16_dec_exe_if.src dec_o
);

    // Bias widened to the exponent sum width
    localparam logic [`FP16_EXP_W+1:0] BIAS_EXT = `FP16_BIAS;

    fp16_mul_pkg::fp16_word_u word_a;
    fp16_mul_pkg::fp16_word_u word_b;
    fp16_mul_pkg::fp_class_e  cls_a;
    fp16_mul_pkg::fp_class_e  cls_b;
    fp16_mul_pkg::fp_class_e  special_d;
    logic                     nv_d;
    logic                     nan_a;
    logic                     nan_b;
    logic signed [`FP16_EXP_W+1:0] exp_a;
    logic signed [`FP16_EXP_W+1:0] exp_b;

    // Class of one operand
    // Zero exponent reads as zero, so subnormals become signed zero
    function automatic fp16_mul_pkg::fp_class_e classify(input fp16_mul_pkg::fp16_word_u w);
        fp16_mul_pkg::fp_class_e cls;
        if (w.f.exp == '0) begin
            cls = fp16_mul_pkg::CLS_ZERO;
        end else if (w.f.exp == `FP16_EXP_MAX) begin
            // Empty payload means infinity, top payload bit marks a quiet NaN
            if (w.raw[`FP16_MAN_W-1:0] == '0) begin
                cls = fp16_mul_pkg::CLS_INF;
            end else if (w.raw[`FP16_MAN_W-1]) begin
                cls = fp16_mul_pkg::CLS_QNAN;
            end else begin
                cls = fp16_mul_pkg::CLS_SNAN;
            end
        end else begin
            cls = fp16_mul_pkg::CLS_NORMAL;
        end
        return cls;
    endfunction

    assign word_a = op_a_i;
    assign word_b = op_b_i;
    assign cls_a  = classify(word_a);
    assign cls_b  = classify(word_b);

    assign nan_a = (cls_a == fp16_mul_pkg::CLS_QNAN) || (cls_a == fp16_mul_pkg::CLS_SNAN);
    assign nan_b = (cls_b == fp16_mul_pkg::CLS_QNAN) || (cls_b == fp16_mul_pkg::CLS_SNAN);

    // Unbiased exponents, two's complement
    assign exp_a = {2'b00, word_a.f.exp} - BIAS_EXT;
    assign exp_b = {2'b00, word_b.f.exp} - BIAS_EXT;

    // Special outcome, NaN has priority over infinity, infinity over zero
    always_comb begin
        nv_d = 1'b0;
        if (nan_a || nan_b) begin
            special_d = fp16_mul_pkg::CLS_QNAN;
            nv_d      = (cls_a == fp16_mul_pkg::CLS_SNAN) || (cls_b == fp16_mul_pkg::CLS_SNAN);
        end else if ((cls_a == fp16_mul_pkg::CLS_INF && cls_b == fp16_mul_pkg::CLS_ZERO) ||
                     (cls_a == fp16_mul_pkg::CLS_ZERO && cls_b == fp16_mul_pkg::CLS_INF)) begin
            // Infinity times zero is invalid
            special_d = fp16_mul_pkg::CLS_QNAN;
            nv_d      = 1'b1;
        end else if (cls_a == fp16_mul_pkg::CLS_INF || cls_b == fp16_mul_pkg::CLS_INF) begin
            special_d = fp16_mul_pkg::CLS_INF;
        end else if (cls_a == fp16_mul_pkg::CLS_ZERO || cls_b == fp16_mul_pkg::CLS_ZERO) begin
            special_d = fp16_mul_pkg::CLS_ZERO;
        end else begin
            special_d = fp16_mul_pkg::CLS_NORMAL;
        end
    end

    // Stage valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= valid_i;
        end
    end

    // Payload, loaded only with a valid pair
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            dec_o.sign    <= word_a.f.sign ^ word_b.f.sign;
            dec_o.exp_sum <= exp_a + exp_b;
            dec_o.man_a   <= {1'b1, word_a.f.man};
            dec_o.man_b   <= {1'b1, word_b.f.man};
            dec_o.special <= special_d;
            dec_o.nv      <= nv_d;
        end
    end

endmodule

/* fp16_execute.sv */
`timescale 1ns/10ps
`include "fp16_mul_config.svh"

module fp16_execute (
    input  logic        clk_i,
    input  logic        rst_n_i,
    fp16_dec_exe_if.dst dec_i,
    fp16_exe_res_if.src exe_o
);

    // Significand product in [1, 4), 2*MAN_W fraction bits
    logic [2*`FP16_MAN_W+1:0] product_d;

    // Multiplier gets a full cycle, rounding stays in the next stage
    assign product_d = dec_i.man_a * dec_i.man_b;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_o.valid <= 1'b0;
        end else begin
            exe_o.valid <= dec_i.valid;
        end
    end

    // Side information travels along with the product
    always_ff @(posedge clk_i) begin
        if (dec_i.valid) begin
            exe_o.sign    <= dec_i.sign;
            exe_o.exp_sum <= dec_i.exp_sum;
            exe_o.product <= product_d;
            exe_o.special <= dec_i.special;
            exe_o.nv      <= dec_i.nv;
        end
    end

endmodule

/* fp16_result.sv */
`timescale 1ns/10ps
`include "fp16_mul_config.svh"

module fp16_result (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    fp16_exe_res_if.dst              exe_i,
    output logic [15:0]              result_o,
    output fp16_mul_pkg::fp_status_t status_o,
    output logic                     valid_o
);

    // Bias and overflow limit at the biased exponent width
    localparam logic [`FP16_EXP_W+2:0]        BIAS_EXT = `FP16_BIAS;
    localparam logic signed [`FP16_EXP_W+2:0] EXP_TOP  = `FP16_EXP_MAX;

    logic                          norm_shift;
    logic [2*`FP16_MAN_W+1:0]      norm;
    logic                          guard;
    logic                          sticky;
    logic                          round_up;
    logic [`FP16_MAN_W+1:0]        sig_rnd;
    logic                          rnd_carry;
    logic [`FP16_MAN_W-1:0]        man_rnd;
    logic signed [`FP16_EXP_W+2:0] exp_adj;
    fp16_mul_pkg::fp16_fields_t    res_d;
    fp16_mul_pkg::fp_status_t      status_d;

    // Product of 2 or more, leading one already at the top
    assign norm_shift = exe_i.product[2*`FP16_MAN_W+1];

    // Otherwise move the leading one up by one place
    assign norm = norm_shift ? exe_i.product : {exe_i.product[2*`FP16_MAN_W:0], 1'b0};

    // Hidden bit at the top, then MAN_W kept bits, then guard, then sticky
    assign guard  = norm[`FP16_MAN_W];
    assign sticky = |norm[`FP16_MAN_W-1:0];

    // Nearest even, a tie rounds up only when the kept LSB is odd
    assign round_up = guard & (sticky | norm[`FP16_MAN_W+1]);

    // One spare bit catches the carry out of rounding
    assign sig_rnd   = {1'b0, norm[2*`FP16_MAN_W+1:`FP16_MAN_W+1]}
                     + {{(`FP16_MAN_W+1){1'b0}}, round_up};
    assign rnd_carry = sig_rnd[`FP16_MAN_W+1];

    // A carry leaves 10.00..0, so renormalize by one place
    assign man_rnd = rnd_carry ? sig_rnd[`FP16_MAN_W:1] : sig_rnd[`FP16_MAN_W-1:0];

    // Biased exponent after both normalization steps
    // Sign extended so that values below zero stay visible
    assign exp_adj = {exe_i.exp_sum[`FP16_EXP_W+1], exe_i.exp_sum}
                   + {{(`FP16_EXP_W+2){1'b0}}, norm_shift}
                   + {{(`FP16_EXP_W+2){1'b0}}, rnd_carry}
                   + BIAS_EXT;

    // Pack result and flags
    always_comb begin
        res_d.sign  = exe_i.sign;
        res_d.exp   = exp_adj[`FP16_EXP_W-1:0];
        res_d.man   = man_rnd;
        status_d    = '0;
        // Any discarded bit makes the result inexact
        status_d.nx = guard | sticky;

        if (exp_adj >= EXP_TOP) begin
            // Too large, signed infinity
            res_d.exp   = '1;
            res_d.man   = '0;
            status_d.of = 1'b1;
            status_d.nx = 1'b1;
        end else if (exp_adj <= 0) begin
            // Below the normal range, flush to signed zero
            res_d.exp   = '0;
            res_d.man   = '0;
            status_d.uf = 1'b1;
            status_d.nx = 1'b1;
        end

        // Special outcomes replace the arithmetic and its flags
        case (exe_i.special)
            fp16_mul_pkg::CLS_QNAN: begin
                res_d       = `FP16_QNAN;
                status_d    = '0;
                status_d.nv = exe_i.nv;
            end
            fp16_mul_pkg::CLS_INF: begin
                res_d.exp = '1;
                res_d.man = '0;
                status_d  = '0;
            end
            fp16_mul_pkg::CLS_ZERO: begin
                res_d.exp = '0;
                res_d.man = '0;
                status_d  = '0;
            end
            default: begin
                // Normal operands, arithmetic result stands
            end
        endcase
    end

    // Output register, holds the last result between valid items
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            status_o <= '0;
        end else begin
            valid_o <= exe_i.valid;
            if (exe_i.valid) begin
                result_o <= res_d;
                status_o <= status_d;
            end
        end
    end

endmodule

/* fp16_mul_top.sv */
`timescale 1ns/10ps

module fp16_mul_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // Operand pair, sampled when valid_i is high
    input  logic [15:0]              op_a_i,
    input  logic [15:0]              op_b_i,
    input  logic                     valid_i,
    // Product and flags, three cycles after the strobe
    output logic [15:0]              result_o,
    output fp16_mul_pkg::fp_status_t status_o,
    output logic                     valid_o
);

    // Stage links
    fp16_dec_exe_if dec_exe ();
    fp16_exe_res_if exe_res ();

    // Classify operands, resolve specials, unpack fields
    fp16_decode u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .op_a_i  (op_a_i),
        .op_b_i  (op_b_i),
        .valid_i (valid_i),
        .dec_o   (dec_exe.src)
    );

    // Significand multiply
    fp16_execute u_execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_i   (dec_exe.dst),
        .exe_o   (exe_res.src)
    );

    // Normalize, round, pack
    fp16_result u_result (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .exe_i    (exe_res.dst),
        .result_o (result_o),
        .status_o (status_o),
        .valid_o  (valid_o)
    );

endmodule

/* tb_fp16_mul.sv */
`timescale 1ns/10ps
`include "fp16_mul_config.svh"

module tb_fp16_mul;

    localparam int CYCLE_LIMIT = 1000;

    logic                     clk;
    logic                     rst_n;
    logic [15:0]              op_a;
    logic [15:0]              op_b;
    logic                     valid_in;
    logic [15:0]              result_out;
    fp16_mul_pkg::fp_status_t status_out;
    logic                     valid_out;

    // Expected {status, result} per strobe with the oldest at the front
    logic [19:0] exp_q[$];
    logic [31:0] rng_state = 32'd31718;
    int          cyc = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    fp16_mul_top dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .valid_i  (valid_in),
        .result_o (result_out),
        .status_o (status_out),
        .valid_o  (valid_out)
    );

    always #50 clk = ~clk;

    // Expected product by the binary16 rules with the flags in the top nibble
    function automatic logic [19:0] ref_mul(input logic [15:0] a, input logic [15:0] b);
        fp16_mul_pkg::fp16_word_u wa, wb;
        fp16_mul_pkg::fp_status_t st;
        logic        sign, a_nan, b_nan, a_snan, b_snan, a_inf, b_inf, a_zero, b_zero;
        logic [15:0] res;
        int          e, prod, sig, rem, half;
        wa = a;
        wb = b;
        st = '0;
        sign = wa.f.sign ^ wb.f.sign;
        a_nan = (wa.f.exp == 5'd31) && (wa.f.man != 0);
        b_nan = (wb.f.exp == 5'd31) && (wb.f.man != 0);
        // Quiet bit is the top payload bit
        a_snan = a_nan && !wa.raw[9];
        b_snan = b_nan && !wb.raw[9];
        a_inf = (wa.f.exp == 5'd31) && (wa.f.man == 0);
        b_inf = (wb.f.exp == 5'd31) && (wb.f.man == 0);
        // Subnormals count as zero
        a_zero = (wa.f.exp == 0);
        b_zero = (wb.f.exp == 0);
        if (a_nan || b_nan) begin
            res = `FP16_QNAN;
            st.nv = a_snan || b_snan;
        end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            res = `FP16_QNAN;
            st.nv = 1'b1;
        end else if (a_inf || b_inf) begin
            res = {sign, 15'h7C00};
        end else if (a_zero || b_zero) begin
            res = {sign, 15'h0000};
        end else begin
            prod = int'({1'b1, wa.f.man}) * int'({1'b1, wb.f.man});
            e = int'(wa.f.exp) + int'(wb.f.exp) - 15;
            // Keep 11 significant bits and the rest as remainder
            if (prod >= (1 << 21)) begin
                sig = prod >> 11;
                rem = prod % 2048;
                half = 1024;
                e = e + 1;
            end else begin
                sig = prod >> 10;
                rem = prod % 1024;
                half = 512;
            end
            if (rem > half || (rem == half && sig % 2 == 1)) sig = sig + 1;
            if (sig == 2048) begin
                sig = 1024;
                e = e + 1;
            end
            st.nx = (rem != 0);
            if (e >= 31) begin
                res = {sign, 15'h7C00};
                st.of = 1'b1;
                st.nx = 1'b1;
            end else if (e <= 0) begin
                res = {sign, 15'h0000};
                st.uf = 1'b1;
                st.nx = 1'b1;
            end else begin
                res = {sign, e[4:0], sig[9:0]};
            end
        end
        return {st, res};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Either a raw word or a normal with a mid-range exponent
    task automatic random_operand(output logic [15:0] op);
        rng_state = xorshift32(rng_state);
        if (rng_state[20])
            op = {rng_state[15], 5'd9 + {1'b0, rng_state[19:16] % 4'd12}, rng_state[9:0]};
        else
            op = rng_state[15:0];
    endtask

    task automatic send_pair(input logic [15:0] a, input logic [15:0] b);
        @(negedge clk);
        op_a = a;
        op_b = b;
        valid_in = 1'b1;
        exp_q.push_back(ref_mul(a, b));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            valid_in = 1'b0;
        end
    endtask

    // Wait for every pending result and leave idle cycles for strays
    task automatic drain_queue();
        int waited;
        idle(1);
        waited = 0;
        while (exp_q.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results never came out of the pipeline", exp_q.size());
            err_count++;
            exp_q.delete();
        end
        idle(2);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("Test %s: ok", name);
            tests_ok++;
        end else begin
            $display("Test %s: %0d errors", name, err_count - errs_before);
            tests_bad++;
        end
    endtask

    task automatic run_random(input int count, input logic with_gaps);
        logic [15:0] a, b;
        for (int i = 0; i < count; i++) begin
            random_operand(a);
            random_operand(b);
            send_pair(a, b);
            if (with_gaps) begin
                rng_state = xorshift32(rng_state);
                if (rng_state[1:0] != 0) idle(int'(rng_state[1:0]));
            end
        end
        drain_queue();
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cyc);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Compare each output with the oldest expected value
    always @(posedge clk) begin
        logic [19:0] exp_v;
        if (valid_out) begin
            if (exp_q.size() == 0) begin
                $display("Output %h came with no pair pending", result_out);
                err_count++;
            end else begin
                exp_v = exp_q.pop_front();
                check_count++;
                assert (result_out == exp_v[15:0]) else begin
                    $display("FAILED result_o expected %h got %h", exp_v[15:0], result_out);
                    err_count++;
                end
                assert (status_out == exp_v[19:16]) else begin
                    $display("FAILED status_o expected %h got %h", exp_v[19:16], status_out);
                    err_count++;
                end
            end
        end
    end

    initial begin
        int errs, strobe_cyc, waited;
        clk = 1'b0;
        rst_n = 1'b0;
        op_a = '0;
        op_b = '0;
        valid_in = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset and then one strobe with its latency
        errs = err_count;
        repeat (4) begin
            @(negedge clk);
            assert (valid_out == 1'b0) else begin
                $display("valid_o went high before any strobe");
                err_count++;
            end
        end
        send_pair(16'h3C00, 16'h3C00);
        // Latency counts from the cycle that carries the strobe
        strobe_cyc = cyc;
        idle(1);
        waited = 0;
        while (!valid_out && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!valid_out) begin
            $display("No output appeared after the first strobe");
            err_count++;
        end else if (cyc - strobe_cyc != 3) begin
            $display("Output came %0d cycles after its strobe, not 3", cyc - strobe_cyc);
            err_count++;
        end
        drain_queue();
        report_test("latency", errs);

        // Signs, plain products, ties to even and a rounding carry
        errs = err_count;
        send_pair(16'h4000, 16'h4200);
        send_pair(16'hBE00, 16'h4000);
        send_pair(16'h3C01, 16'h3E00);
        send_pair(16'h3C03, 16'h3E00);
        send_pair(16'hC500, 16'hB555);
        send_pair(16'h3DA8, 16'h3DA8);
        drain_queue();
        report_test("normal products", errs);

        errs = err_count;
        send_pair(16'h7C00, 16'h0000);
        send_pair(16'h0000, 16'hFC00);
        send_pair(16'h7D00, 16'h3C00);
        send_pair(16'h7E00, 16'h3C00);
        send_pair(16'h3C00, 16'hFE01);
        send_pair(16'h7C00, 16'hC000);
        send_pair(16'h8000, 16'h3C00);
        send_pair(16'h0001, 16'h4000);
        send_pair(16'h8200, 16'h3C00);
        drain_queue();
        report_test("special operands", errs);

        // Overflow, rounding into overflow, underflow
        errs = err_count;
        send_pair(16'h7BFF, 16'h7BFF);
        send_pair(16'hC000, 16'h7800);
        send_pair(16'h79A8, 16'h3DA8);
        send_pair(16'h0400, 16'h0400);
        send_pair(16'h8400, 16'h3800);
        drain_queue();
        report_test("range limits", errs);

        errs = err_count;
        run_random(400, 1'b0);
        report_test("random back to back", errs);

        errs = err_count;
        run_random(50, 1'b1);
        report_test("random with gaps", errs);

        $display("Tests ok %0d, failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, check_count, err_count);
        if (err_count == 0 && tests_bad == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
fp16_mul_pkg.sv
fp16_mul_ifs.sv
fp16_decode.sv
fp16_execute.sv
fp16_result.sv
fp16_mul_top.sv
tb_fp16_mul.sv

/* run_sim.sh */
#!/bin/sh
# Build the fp16 multiplier testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_fp16_mul \
    && ./obj_dir/Vtb_fp16_mul | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
